/* source/bank_sram_pkg.sv */
`default_nettype none

package bank_sram_pkg;

	//====================================================================
	// Geometry
	//====================================================================

	// Word width in bits
	localparam int BW = 8;
	// Words held by one bank
	localparam int NDATA = 32;
	// Banks, and lanes per request
	localparam int NBANK = 16;
	// High address bits the hash scheme may pick from
	localparam int XOR_BW = 4;
	// Request tag width
	localparam int ID_BW = 2;

	// Derived widths
	localparam int CLOG2_NDATA = $clog2(NDATA);
	localparam int CLOG2_NBANK = $clog2(NBANK);
	// Enough bits to rotate by any power of two up to the lane index width
	localparam int CCLOG2_NBANK = $clog2(CLOG2_NBANK + 1);
	// Lane address is {row, logical bank}
	localparam int ABW = CLOG2_NDATA + CLOG2_NBANK;
	localparam int CLOG2_XOR_BW = $clog2(XOR_BW);

	//====================================================================
	// Bundles
	//====================================================================

	// Bank hash configuration
	typedef struct packed {
		logic [CLOG2_NBANK-1:0]                   xor_mask;
		logic [CLOG2_NBANK-1:0][CLOG2_XOR_BW-1:0] xor_scheme;
	} hash_cfg_t;

	// Read request, one address per lane
	typedef struct packed {
		logic [ID_BW-1:0]                id;
		logic                            retire;
		logic [CCLOG2_NBANK-1:0]         bit_swap;
		logic [NBANK-1:0][ABW-1:0]       raddr;
	} rd_req_t;

	// Write request, one address and word per lane
	typedef struct packed {
		logic [NBANK-1:0][ABW-1:0] waddr;
		logic [NBANK-1:0][BW-1:0]  wdata;
	} wr_req_t;

	// One word per lane or per bank
	typedef logic [NBANK-1:0][BW-1:0] lane_data_t;

	// Physical bank of each lane
	typedef logic [NBANK-1:0][CLOG2_NBANK-1:0] bank_idx_t;

	// Per-bank SRAM control, indexed by physical bank
	typedef struct packed {
		logic [NBANK-1:0]                  en;
		logic [NBANK-1:0]                  we;
		logic [NBANK-1:0][CLOG2_NDATA-1:0] addr;
		lane_data_t                        wdata;
	} sram_port_t;

endpackage

`default_nettype wire

/* source/rdyack_forward.sv */
`timescale 1ns/1ns
`default_nettype none

module rdyack_forward (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_src_rdy,
	output logic o_src_ack,
	output logic o_dst_rdy,
	input  logic i_dst_ack
);

	// Slice holds an item
	logic full_r;

	// Item leaving this cycle
	logic leave;

	assign leave = full_r && i_dst_ack;

	// Take a new item when empty, or in the cycle the old one leaves
	assign o_src_ack = i_src_rdy && (!full_r || leave);

	assign o_dst_rdy = full_r;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			full_r <= 1'b0;
		end else if (o_src_ack) begin
			full_r <= 1'b1;
		end else if (leave) begin
			full_r <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/bank_xor_map.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_xor_map (
	input  logic [bank_sram_pkg::NBANK-1:0][bank_sram_pkg::ABW-1:0] i_addr,
	input  bank_sram_pkg::hash_cfg_t                                i_cfg,
	output bank_sram_pkg::bank_idx_t                                o_bank
);

	import bank_sram_pkg::*;

	// Butterfly bits picked from the high address part
	bank_idx_t bfly;

	// Logical bank straight from the low address bits
	bank_idx_t logical;

	always_comb begin
		for (int l = 0; l < NBANK; l++) begin
			logical[l] = i_addr[l][CLOG2_NBANK-1:0];
			// Bank bit j is hashed with the address bit the scheme names
			for (int j = 0; j < CLOG2_NBANK; j++) begin
				bfly[l][j] = i_addr[l][CLOG2_NBANK + int'(i_cfg.xor_scheme[j])];
			end
		end
	end

	// Masked XOR gives the physical bank
	always_comb begin
		for (int l = 0; l < NBANK; l++) begin
			o_bank[l] = logical[l] ^ (i_cfg.xor_mask & bfly[l]);
		end
	end

endmodule

`default_nettype wire

/* source/bank_sram_read_if.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_sram_read_if (
	input  logic                                                     i_clk,
	input  logic                                                     i_rst_n,
	// Address request
	input  logic                                                     i_addrin_rdy,
	output logic                                                     o_addrin_ack,
	input  bank_sram_pkg::rd_req_t                                   i_req,
	input  bank_sram_pkg::bank_idx_t                                 i_lane_bank,
	// Read data out
	output logic                                                     o_dout_rdy,
	input  logic                                                     i_dout_ack,
	output bank_sram_pkg::lane_data_t                                o_rdata,
	// Retire report
	output logic                                                     o_free_dval,
	output logic [bank_sram_pkg::ID_BW-1:0]                          o_free_id,
	// Bank side
	output logic [bank_sram_pkg::NBANK-1:0]                          o_sram_re,
	output logic [bank_sram_pkg::NBANK-1:0][bank_sram_pkg::CLOG2_NDATA-1:0] o_sram_raddr,
	input  bank_sram_pkg::lane_data_t                                i_sram_rdata
);

	import bank_sram_pkg::*;

	//====================================================================
	// Stage control
	//====================================================================

	logic s1_rdy;
	logic s1_ack;

	// addrin -> s1
	rdyack_forward u_fwd_addr (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_src_rdy (i_addrin_rdy),
		.o_src_ack (o_addrin_ack),
		.o_dst_rdy (s1_rdy),
		.i_dst_ack (s1_ack)
	);

	// s1 -> dout
	rdyack_forward u_fwd_dat (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_src_rdy (s1_rdy),
		.o_src_ack (s1_ack),
		.o_dst_rdy (o_dout_rdy),
		.i_dst_ack (i_dout_ack)
	);

	//====================================================================
	// Address routing
	//====================================================================

	// Per bank, a tree over the lanes; level 0 nodes are the lanes
	logic                   lvl_en  [CLOG2_NBANK+1][NBANK][NBANK];
	logic [CLOG2_NDATA-1:0] lvl_row [CLOG2_NBANK+1][NBANK][NBANK];

	always_comb begin
		lvl_en  = '{default: '{default: '{default: 1'b0}}};
		lvl_row = '{default: '{default: '{default: '0}}};
		for (int b = 0; b < NBANK; b++) begin
			// Lanes that target bank b
			for (int l = 0; l < NBANK; l++) begin
				lvl_en[0][b][l]  = (i_lane_bank[l] == CLOG2_NBANK'(b));
				lvl_row[0][b][l] = i_req.raddr[l][ABW-1 -: CLOG2_NDATA];
			end
			// Each level halves the candidates
			for (int v = 0; v < CLOG2_NBANK; v++) begin
				for (int n = 0; n < (NBANK >> (v + 1)); n++) begin
					lvl_en[v+1][b][n] = lvl_en[v][b][2*n] || lvl_en[v][b][2*n+1];
					lvl_row[v+1][b][n] = lvl_en[v][b][2*n] ?
						lvl_row[v][b][2*n] : lvl_row[v][b][2*n+1];
				end
			end
		end
	end

	always_comb begin
		for (int b = 0; b < NBANK; b++) begin
			// Banks are only read on the address acknowledge
			o_sram_re[b]    = o_addrin_ack && lvl_en[CLOG2_NBANK][b][0];
			o_sram_raddr[b] = lvl_row[CLOG2_NBANK][b][0];
		end
	end

	//====================================================================
	// s1 slice
	//====================================================================

	bank_idx_t               s1_lane_bank_r;
	logic [CCLOG2_NBANK-1:0] s1_bit_swap_r;
	logic [ID_BW-1:0]        s1_id_r;
	logic                    s1_retire_r;

	always_ff @(posedge i_clk) begin
		if (o_addrin_ack) begin
			s1_lane_bank_r <= i_lane_bank;
			s1_bit_swap_r  <= i_req.bit_swap;
			s1_id_r        <= i_req.id;
			s1_retire_r    <= i_req.retire;
		end
	end

	//====================================================================
	// Data return
	//====================================================================

	// Rotate a lane index left by the sum of 2^b over set swap bits
	function automatic logic [CLOG2_NBANK-1:0] rot_idx(
		input logic [CLOG2_NBANK-1:0]  idx,
		input logic [CCLOG2_NBANK-1:0] swap
	);
		logic [CLOG2_NBANK-1:0] r;
		r = idx;
		for (int b = 0; b < CCLOG2_NBANK; b++) begin
			if (swap[b]) begin
				for (int n = 0; n < ((1 << b) % CLOG2_NBANK); n++) begin
					r = {r[CLOG2_NBANK-2:0], r[CLOG2_NBANK-1]};
				end
			end
		end
		return r;
	endfunction

	lane_data_t unrouted;
	lane_data_t rotated;

	always_comb begin
		// Each lane picks the word of the bank that served it
		for (int l = 0; l < NBANK; l++) begin
			unrouted[l] = i_sram_rdata[s1_lane_bank_r[l]];
		end
		for (int j = 0; j < NBANK; j++) begin
			rotated[j] = unrouted[rot_idx(CLOG2_NBANK'(j), s1_bit_swap_r)];
		end
	end

	logic dout_retire_r;

	always_ff @(posedge i_clk) begin
		if (s1_ack) begin
			o_rdata       <= rotated;
			o_free_id     <= s1_id_r;
			dout_retire_r <= s1_retire_r;
		end
	end

	// One pulse per retiring request, on its dout transfer
	assign o_free_dval = o_dout_rdy && i_dout_ack && dout_retire_r;

endmodule

`default_nettype wire

/* source/bank_sram_write_if.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_sram_write_if (
	input  logic                                                            i_wr_rdy,
	output logic                                                            o_wr_ack,
	input  bank_sram_pkg::wr_req_t                                          i_wr,
	input  bank_sram_pkg::bank_idx_t                                        i_lane_bank,
	// Read owns the banks this cycle
	input  logic                                                            i_rd_busy,
	output logic [bank_sram_pkg::NBANK-1:0]                                 o_sram_we,
	output logic [bank_sram_pkg::NBANK-1:0][bank_sram_pkg::CLOG2_NDATA-1:0] o_sram_waddr,
	output bank_sram_pkg::lane_data_t                                       o_sram_wdata
);

	import bank_sram_pkg::*;

	// Bank is the target of some lane
	logic [NBANK-1:0] hit;

	// Reads win the banks
	assign o_wr_ack = i_wr_rdy && !i_rd_busy;

	// Scatter lanes onto their hashed banks
	always_comb begin
		hit          = '0;
		o_sram_waddr = '0;
		o_sram_wdata = '0;
		for (int b = 0; b < NBANK; b++) begin
			for (int l = 0; l < NBANK; l++) begin
				// At most one lane per bank in a valid request
				if (i_lane_bank[l] == CLOG2_NBANK'(b)) begin
					hit[b]          = 1'b1;
					o_sram_waddr[b] = i_wr.waddr[l][ABW-1 -: CLOG2_NDATA];
					o_sram_wdata[b] = i_wr.wdata[l];
				end
			end
		end
	end

	// Write enables only on the acknowledge edge
	assign o_sram_we = o_wr_ack ? hit : '0;

endmodule

`default_nettype wire

/* source/bank_sram_array.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_sram_array (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  bank_sram_pkg::sram_port_t i_port,
	output bank_sram_pkg::lane_data_t o_rdata
);

	import bank_sram_pkg::*;

	// One single-port array per bank
	logic [BW-1:0] mem [NBANK][NDATA];

	// Write or read per bank
	// Read data held until the next read
	always_ff @(posedge i_clk) begin
		for (int b = 0; b < NBANK; b++) begin
			// No access while reset is held
			if (i_rst_n && i_port.en[b]) begin
				if (i_port.we[b]) begin
					mem[b][i_port.addr[b]] <= i_port.wdata[b];
				end else begin
					o_rdata[b] <= mem[b][i_port.addr[b]];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/bank_sram_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_sram_top (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  bank_sram_pkg::hash_cfg_t        i_cfg,
	// Read request
	input  logic                            i_addrin_rdy,
	output logic                            o_addrin_ack,
	input  bank_sram_pkg::rd_req_t          i_req,
	// Read data
	output logic                            o_dout_rdy,
	input  logic                            i_dout_ack,
	output bank_sram_pkg::lane_data_t       o_rdata,
	// Retire report
	output logic                            o_free_dval,
	output logic [bank_sram_pkg::ID_BW-1:0] o_free_id,
	// Write request
	input  logic                            i_wr_rdy,
	output logic                            o_wr_ack,
	input  bank_sram_pkg::wr_req_t          i_wr
);

	import bank_sram_pkg::*;

	//====================================================================
	// Bank hash
	//====================================================================

	bank_idx_t rd_bank;
	bank_idx_t wr_bank;

	bank_xor_map u_rd_map (
		.i_addr (i_req.raddr),
		.i_cfg  (i_cfg),
		.o_bank (rd_bank)
	);

	bank_xor_map u_wr_map (
		.i_addr (i_wr.waddr),
		.i_cfg  (i_cfg),
		.o_bank (wr_bank)
	);

	//====================================================================
	// Read and write sides
	//====================================================================

	logic [NBANK-1:0]                  rd_re;
	logic [NBANK-1:0][CLOG2_NDATA-1:0] rd_raddr;
	lane_data_t                        bank_rdata;
	logic [NBANK-1:0]                  wr_we;
	logic [NBANK-1:0][CLOG2_NDATA-1:0] wr_waddr;
	lane_data_t                        wr_wdata;

	bank_sram_read_if u_read_if (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_addrin_rdy (i_addrin_rdy),
		.o_addrin_ack (o_addrin_ack),
		.i_req        (i_req),
		.i_lane_bank  (rd_bank),
		.o_dout_rdy   (o_dout_rdy),
		.i_dout_ack   (i_dout_ack),
		.o_rdata      (o_rdata),
		.o_free_dval  (o_free_dval),
		.o_free_id    (o_free_id),
		.o_sram_re    (rd_re),
		.o_sram_raddr (rd_raddr),
		.i_sram_rdata (bank_rdata)
	);

	bank_sram_write_if u_write_if (
		.i_wr_rdy     (i_wr_rdy),
		.o_wr_ack     (o_wr_ack),
		.i_wr         (i_wr),
		.i_lane_bank  (wr_bank),
		.i_rd_busy    (o_addrin_ack),
		.o_sram_we    (wr_we),
		.o_sram_waddr (wr_waddr),
		.o_sram_wdata (wr_wdata)
	);

	// Merge bank controls
	// Read row wins where a bank is read
	sram_port_t sram_port;

	always_comb begin
		sram_port.en    = rd_re | wr_we;
		sram_port.we    = wr_we;
		sram_port.wdata = wr_wdata;
		for (int b = 0; b < NBANK; b++) begin
			sram_port.addr[b] = rd_re[b] ? rd_raddr[b] : wr_waddr[b];
		end
	end

	bank_sram_array u_array (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_port  (sram_port),
		.o_rdata (bank_rdata)
	);

endmodule

`default_nettype wire

/* tests/tb_bank_sram.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_bank_sram;

	import bank_sram_pkg::*;

	typedef logic [NBANK-1:0][ABW-1:0] lane_addr_t;

	logic             i_clk;
	logic             i_rst_n;
	hash_cfg_t        i_cfg;
	logic             i_addrin_rdy;
	logic             o_addrin_ack;
	rd_req_t          i_req;
	logic             o_dout_rdy;
	logic             i_dout_ack;
	lane_data_t       o_rdata;
	logic             o_free_dval;
	logic [ID_BW-1:0] o_free_id;
	logic             i_wr_rdy;
	logic             o_wr_ack;
	wr_req_t          i_wr;

	bank_sram_top i_dut (.*);

	// Reference contents by physical bank and row
	logic [BW-1:0] model [NBANK][NDATA];
	logic [31:0]   lcg_state;
	// Read requests for the next stream
	rd_req_t       rq[$];
	// Write held ready alongside a read stream
	logic          wr_pending;
	wr_req_t       wr_req;

	always #20 i_clk = ~i_clk;

	// ====================================================================
	// Reference helpers
	// ====================================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Word pattern mixing every address bit
	function automatic logic [BW-1:0] fill_word(input logic [ABW-1:0] a, input logic [BW-1:0] salt);
		return a[7:0] ^ {a[8], a[8:2]} ^ salt;
	endfunction

	// Low bits XOR masked scheme-selected row bits
	function automatic logic [CLOG2_NBANK-1:0] hash_bank(input logic [ABW-1:0] a);
		logic [CLOG2_NBANK-1:0] bf;
		for (int j = 0; j < CLOG2_NBANK; j++) begin
			bf[j] = a[CLOG2_NBANK + int'(i_cfg.xor_scheme[j])];
		end
		return a[CLOG2_NBANK-1:0] ^ (i_cfg.xor_mask & bf);
	endfunction

	// Shuffle target banks, then pick the logical bank that hashes onto each
	function automatic lane_addr_t conflict_free_addrs();
		logic [CLOG2_NBANK-1:0] perm [NBANK];
		logic [CLOG2_NBANK-1:0] t;
		logic [CLOG2_NBANK-1:0] base;
		logic [31:0]            rnd;
		lane_addr_t             a;
		int                     j;
		for (int i = 0; i < NBANK; i++) begin
			perm[i] = CLOG2_NBANK'(i);
		end
		for (int i = NBANK - 1; i > 0; i--) begin
			rnd = lcg_next();
			j = int'(rnd[23:16]) % (i + 1);
			t = perm[i];
			perm[i] = perm[j];
			perm[j] = t;
		end
		for (int l = 0; l < NBANK; l++) begin
			rnd = lcg_next();
			// Masked butterfly term of this row alone
			base = hash_bank({rnd[20:16], 4'b0000});
			a[l] = {rnd[20:16], perm[l] ^ base};
		end
		return a;
	endfunction

	function automatic rd_req_t random_read(input logic [CCLOG2_NBANK-1:0] swap,
		input logic [ID_BW-1:0] id, input logic retire);
		rd_req_t r;
		r.raddr    = conflict_free_addrs();
		r.bit_swap = swap;
		r.id       = id;
		r.retire   = retire;
		return r;
	endfunction

	function automatic wr_req_t random_write(input logic [BW-1:0] salt);
		wr_req_t w;
		w.waddr = conflict_free_addrs();
		for (int l = 0; l < NBANK; l++) begin
			w.wdata[l] = fill_word(w.waddr[l], salt);
		end
		return w;
	endfunction

	function automatic void apply_write(input wr_req_t w);
		for (int l = 0; l < NBANK; l++) begin
			model[hash_bank(w.waddr[l])][w.waddr[l][ABW-1:CLOG2_NBANK]] = w.wdata[l];
		end
	endfunction

	// Output lane j shows lane k
	// k is j rotated left by the swap sum
	function automatic lane_data_t expect_rdata(input rd_req_t r);
		lane_data_t             d;
		logic [CLOG2_NBANK-1:0] k;
		for (int j = 0; j < NBANK; j++) begin
			k = CLOG2_NBANK'(j);
			for (int n = 0; n < int'(r.bit_swap) % CLOG2_NBANK; n++) begin
				k = {k[CLOG2_NBANK-2:0], k[CLOG2_NBANK-1]};
			end
			d[j] = model[hash_bank(r.raddr[k])][r.raddr[k][ABW-1:CLOG2_NBANK]];
		end
		return d;
	endfunction

	// ====================================================================
	// Checks and drivers
	// ====================================================================

	task automatic check_equal(input logic [127:0] got, input logic [127:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "stopped on the first error");
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s at %0t ns", what, $time);
		$display("Regression failed");
		$fatal(1, "stopped on the first error");
	endtask

	task automatic write_lanes(input wr_req_t w);
		int cyc;
		cyc = 0;
		@(negedge i_clk);
		i_wr_rdy = 1'b1;
		i_wr     = w;
		#1;
		while (!o_wr_ack) begin
			cyc++;
			if (cyc > 20) abort_run("Write was never acknowledged");
			@(negedge i_clk);
			#1;
		end
		apply_write(w);
		@(negedge i_clk);
		i_wr_rdy = 1'b0;
	endtask

	// Streams rq through the read port; dout ack is held low for stall cycles
	task automatic run_reads(input int stall);
		lane_data_t exq[$];
		rd_req_t    accq[$];
		rd_req_t    done;
		logic       exp_free;
		logic       exp_addr_ack;
		int         sent;
		int         got;
		int         cyc;
		sent = 0;
		got  = 0;
		cyc  = 0;
		while (got < rq.size()) begin
			@(negedge i_clk);
			i_addrin_rdy = (sent < rq.size());
			if (sent < rq.size()) i_req = rq[sent];
			i_dout_ack = (cyc >= stall);
			i_wr_rdy   = wr_pending;
			i_wr       = wr_req;
			#1;
			// Two requests held in the slices block the address port
			exp_addr_ack = i_addrin_rdy && (((sent - got) < 2) || i_dout_ack);
			check_equal(128'(o_addrin_ack), 128'(exp_addr_ack), "address ack");
			// Reads own the banks in any cycle they are acknowledged
			check_equal(128'(o_wr_ack), 128'(i_wr_rdy && !exp_addr_ack), "write ack");
			if (o_wr_ack) begin
				apply_write(i_wr);
				wr_pending = 1'b0;
			end
			// Bank data are taken on the address ack edge
			if (o_addrin_ack) begin
				exq.push_back(expect_rdata(rq[sent]));
				accq.push_back(rq[sent]);
				sent++;
			end
			exp_free = 1'b0;
			if (o_dout_rdy && i_dout_ack) begin
				if (exq.size() == 0) abort_run("Read data came out with no request in flight");
				check_equal(o_rdata, exq.pop_front(), "read data");
				done     = accq.pop_front();
				exp_free = done.retire;
				if (exp_free) check_equal(128'(o_free_id), 128'(done.id), "free id");
				got++;
			end
			check_equal(128'(o_free_dval), 128'(exp_free), "free pulse");
			cyc++;
			if (cyc > 300) abort_run("Timed out waiting for read results");
		end
		@(negedge i_clk);
		i_addrin_rdy = 1'b0;
		i_dout_ack   = 1'b0;
		i_wr_rdy     = wr_pending;
		rq.delete();
	endtask

	// ====================================================================
	// Directed tests
	// ====================================================================

	// Fill all words with no hash, read back in identity lane order
	task automatic linear_fill();
		wr_req_t w;
		rd_req_t r;
		@(negedge i_clk);
		i_cfg = '0;
		for (int row = 0; row < NDATA; row++) begin
			for (int l = 0; l < NBANK; l++) begin
				w.waddr[l] = {5'(row), 4'(l)};
				w.wdata[l] = fill_word(w.waddr[l], 8'h00);
			end
			write_lanes(w);
		end
		for (int row = 0; row < NDATA; row++) begin
			r       = '0;
			r.id    = 2'(row);
			for (int l = 0; l < NBANK; l++) r.raddr[l] = {5'(row), 4'(l)};
			rq.push_back(r);
		end
		run_reads(0);
	endtask

	task automatic hashed_random_reads();
		logic [31:0] rnd;
		for (int c = 0; c < 4; c++) begin
			rnd = lcg_next();
			i_cfg.xor_mask   = rnd[19:16] | 4'b0001;
			i_cfg.xor_scheme = rnd[27:20];
			for (int n = 0; n < 6; n++) write_lanes(random_write(8'(c + 1)));
			for (int n = 0; n < 8; n++) rq.push_back(random_read(3'd0, 2'(n), 1'b0));
			run_reads(0);
		end
	endtask

	task automatic rotate_sweep();
		for (int s = 0; s < 8; s++) rq.push_back(random_read(3'(s), 2'(s), 1'b0));
		run_reads(0);
	endtask

	task automatic backpressure_order();
		for (int n = 0; n < 5; n++) rq.push_back(random_read(3'(lcg_next() >> 16), 2'(n), 1'b0));
		run_reads(6);
	endtask

	task automatic retire_pulses();
		for (int n = 0; n < 6; n++) rq.push_back(random_read(3'd0, 2'(n), 1'(n % 2)));
		run_reads(2);
	endtask

	// Write pending over a read burst, then read its addresses back
	task automatic write_yields_to_reads();
		rd_req_t r;
		wr_req     = random_write(8'h5a);
		wr_pending = 1'b1;
		for (int n = 0; n < 6; n++) rq.push_back(random_read(3'd0, 2'(n), 1'b0));
		run_reads(3);
		if (wr_pending) write_lanes(wr_req);
		wr_pending = 1'b0;
		r       = random_read(3'd0, 2'd3, 1'b1);
		r.raddr = wr_req.waddr;
		rq.push_back(r);
		run_reads(0);
	endtask

	initial begin
		lcg_state    = 32'd38844;
		i_clk        = 1'b0;
		i_rst_n      = 1'b0;
		i_cfg        = '0;
		i_addrin_rdy = 1'b0;
		i_req        = '0;
		i_dout_ack   = 1'b0;
		i_wr_rdy     = 1'b0;
		i_wr         = '0;
		wr_pending   = 1'b0;
		wr_req       = '0;
		repeat (3) @(negedge i_clk);
		i_rst_n = 1'b1;
		#1;
		check_equal(128'({o_dout_rdy, o_free_dval, o_wr_ack}), 128'(0), "idle after reset");
		linear_fill();
		hashed_random_reads();
		rotate_sweep();
		backpressure_order();
		retire_pulses();
		write_yields_to_reads();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
source/bank_sram_pkg.sv
source/rdyack_forward.sv
source/bank_xor_map.sv
source/bank_sram_read_if.sv
source/bank_sram_write_if.sv
source/bank_sram_array.sv
source/bank_sram_top.sv
tests/tb_bank_sram.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
verilator --binary --timing -j 0 --top-module tb_bank_sram -f verilog.f
out=$(./obj_dir/Vtb_bank_sram 2>&1) || true
echo "$out"
if echo "$out" | grep -q "Regression passed"; then
	exit 0
fi
exit 1
